//--- src/simd_alu_defines.svh
`ifndef SIMD_ALU_DEFINES_SVH
`define SIMD_ALU_DEFINES_SVH

// Datapath word width in bits
`define SIMD_DATA_W 64

// One flag per byte of the word
`define SIMD_STRB_W 8

// Width of the reduction beat count
`define SIMD_VL_W 4

`endif

//--- src/simd_alu_pkg.sv
`default_nettype none

`include "simd_alu_defines.svh"

package simd_alu_pkg;

  typedef logic [`SIMD_DATA_W-1:0] simd_word_t;
  typedef logic [`SIMD_STRB_W-1:0] byte_strb_t;
  typedef logic [`SIMD_VL_W-1:0]   beat_cnt_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } elem_width_e;

  // Kept vector integer operations
  typedef enum logic [4:0] {
    VAND, VOR, VXOR,
    VADD, VSUB,
    VSADDU, VSADD, VSSUBU,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSLTU, VMSLT,
    VREDSUM, VREDMAXU, VREDMAX
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCUM,
    ST_HOLD
  } ctrl_state_e;

  typedef struct packed {
    alu_op_e     op;
    elem_width_e vew;
    beat_cnt_t   vl;
  } alu_req_t;

  typedef struct packed {
    simd_word_t data;
    byte_strb_t sat;
  } alu_resp_t;

endpackage

`default_nettype wire

//--- src/simd_compare_unit.sv
`timescale 1ns/1ps
`default_nettype none

module simd_compare_unit import simd_alu_pkg::*; (
  input  simd_word_t  opa_i,
  input  simd_word_t  opb_i,
  input  elem_width_e vew_i,
  input  logic        signed_i,
  output byte_strb_t  less_o,
  output byte_strb_t  equal_o
);

  // B < A per element, flag sits at the element's lowest byte
  always_comb begin
    less_o  = '0;
    equal_o = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        less_o[e]  = $signed({signed_i & opb_i[8*e+7], opb_i[8*e +: 8]}) <
                     $signed({signed_i & opa_i[8*e+7], opa_i[8*e +: 8]});
        equal_o[e] = opb_i[8*e +: 8] == opa_i[8*e +: 8];
      end
      EW16: for (int e = 0; e < 4; e++) begin
        less_o[2*e]  = $signed({signed_i & opb_i[16*e+15], opb_i[16*e +: 16]}) <
                       $signed({signed_i & opa_i[16*e+15], opa_i[16*e +: 16]});
        equal_o[2*e] = opb_i[16*e +: 16] == opa_i[16*e +: 16];
      end
      EW32: for (int e = 0; e < 2; e++) begin
        less_o[4*e]  = $signed({signed_i & opb_i[32*e+31], opb_i[32*e +: 32]}) <
                       $signed({signed_i & opa_i[32*e+31], opa_i[32*e +: 32]});
        equal_o[4*e] = opb_i[32*e +: 32] == opa_i[32*e +: 32];
      end
      EW64: begin
        less_o[0]  = $signed({signed_i & opb_i[63], opb_i}) <
                     $signed({signed_i & opa_i[63], opa_i});
        equal_o[0] = opb_i == opa_i;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/simd_lane_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "simd_alu_defines.svh"

module simd_lane_alu import simd_alu_pkg::*; (
  input  alu_op_e     op_i,
  input  elem_width_e vew_i,
  input  simd_word_t  opa_i,
  input  simd_word_t  opb_i,
  output alu_resp_t   resp_o
);

  logic       is_signed;
  logic       is_sub;
  logic       is_max;
  byte_strb_t less;
  byte_strb_t equal;
  byte_strb_t first;
  byte_strb_t last;
  byte_strb_t carry;
  byte_strb_t sat;
  byte_strb_t clip_neg;
  byte_strb_t pick_b;
  simd_word_t sum;
  simd_word_t res;

  assign is_signed = op_i inside {VMIN, VMAX, VMSLT, VREDMAX};
  assign is_sub    = op_i inside {VSUB, VSSUBU};
  assign is_max    = op_i inside {VMAX, VMAXU, VREDMAXU, VREDMAX};

  simd_compare_unit i_simd_compare_unit (
    .opa_i    (opa_i),
    .opb_i    (opb_i),
    .vew_i    (vew_i),
    .signed_i (is_signed),
    .less_o   (less),
    .equal_o  (equal)
  );

  //////////////////////////////////////////////////////////////////////
  // Element boundaries and byte carry chain

  always_comb begin
    logic [2:0] span;
    unique case (vew_i)
      EW8:     span = 3'd0;
      EW16:    span = 3'd1;
      EW32:    span = 3'd3;
      default: span = 3'd7;
    endcase
    for (int b = 0; b < `SIMD_STRB_W; b++) begin
      first[b] = (b[2:0] & span) == 3'd0;
      last[b]  = (b[2:0] & span) == span;
    end
  end

  // B + A, or B + ~A + 1 for subtraction; carry cut at element starts
  always_comb begin
    logic       cin;
    logic [8:0] part;
    cin = 1'b0;
    for (int b = 0; b < `SIMD_STRB_W; b++) begin
      if (first[b]) cin = is_sub;
      part = {1'b0, opb_i[8*b +: 8]} + {1'b0, is_sub ? ~opa_i[8*b +: 8] : opa_i[8*b +: 8]}
           + 9'(cin);
      sum[8*b +: 8] = part[7:0];
      carry[b]      = part[8];
      cin           = part[8];
    end
  end

  // Overflow found at the top byte, spread down over the element
  always_comb begin
    logic ovf;
    logic neg;
    ovf = 1'b0;
    neg = 1'b0;
    for (int b = `SIMD_STRB_W - 1; b >= 0; b--) begin
      if (last[b]) begin
        unique case (op_i)
          VSADDU:  ovf = carry[b];
          VSSUBU:  ovf = ~carry[b];
          VSADD:   ovf = (opa_i[8*b+7] == opb_i[8*b+7]) && (sum[8*b+7] != opa_i[8*b+7]);
          default: ovf = 1'b0;
        endcase
        neg = opa_i[8*b+7];
      end
      sat[b]      = ovf;
      clip_neg[b] = neg;
    end
  end

  // Min/max choice made at the lowest byte, spread up
  always_comb begin
    logic sel;
    sel = 1'b0;
    for (int b = 0; b < `SIMD_STRB_W; b++) begin
      if (first[b]) sel = less[b] ^ is_max;
      pick_b[b] = sel;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result select

  always_comb begin
    logic [7:0] clip;
    res = '0;
    for (int b = 0; b < `SIMD_STRB_W; b++) begin
      // 0x7f / 0x80 at the top byte, 0xff / 0x00 below
      clip = {last[b] ^ ~clip_neg[b], {7{~clip_neg[b]}}};
      unique case (op_i)
        VAND:                  res[8*b +: 8] = opa_i[8*b +: 8] & opb_i[8*b +: 8];
        VOR:                   res[8*b +: 8] = opa_i[8*b +: 8] | opb_i[8*b +: 8];
        VXOR:                  res[8*b +: 8] = opa_i[8*b +: 8] ^ opb_i[8*b +: 8];
        VADD, VSUB, VREDSUM:   res[8*b +: 8] = sum[8*b +: 8];
        VSADDU:                res[8*b +: 8] = sat[b] ? 8'hff : sum[8*b +: 8];
        VSSUBU:                res[8*b +: 8] = sat[b] ? 8'h00 : sum[8*b +: 8];
        VSADD:                 res[8*b +: 8] = sat[b] ? clip : sum[8*b +: 8];
        VMINU, VMIN, VMAXU, VMAX, VREDMAXU, VREDMAX:
          res[8*b +: 8] = pick_b[b] ? opb_i[8*b +: 8] : opa_i[8*b +: 8];
        VMSEQ:                 res[8*b +: 8] = {7'd0, equal[b]};
        VMSLTU, VMSLT:         res[8*b +: 8] = {7'd0, less[b]};
        default:               res[8*b +: 8] = 8'h00;
      endcase
    end
  end

  assign resp_o = '{data: res, sat: sat};

  always_comb begin
    if (!(op_i inside {VAND, VOR, VXOR})) begin
      assert (!$isunknown(vew_i)) else $error("element width unknown for op %0d", op_i);
    end
  end

endmodule

`default_nettype wire

//--- src/simd_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module simd_accumulator import simd_alu_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       load_i,
  input  logic       use_acc_i,
  input  simd_word_t operand_a_i,
  input  alu_resp_t  alu_resp_i,
  output simd_word_t opa_o,
  output alu_resp_t  resp_o
);

  // Output word, doubles as the running reduction value
  alu_resp_t acc_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_q <= '0;
    end else if (load_i) begin
      acc_q <= alu_resp_i;
    end
  end

  assign opa_o  = use_acc_i ? acc_q.data : operand_a_i;
  assign resp_o = acc_q;

endmodule

`default_nettype wire

//--- src/simd_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module simd_beat_counter import simd_alu_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      load_i,
  input  logic      step_i,
  input  beat_cnt_t vl_i,
  output logic      last_o
);

  // Beats still to come, counting the current one
  beat_cnt_t remain_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      remain_q <= '0;
    end else if (load_i) begin
      remain_q <= vl_i - beat_cnt_t'(1);
    end else if (step_i) begin
      remain_q <= remain_q - beat_cnt_t'(1);
    end
  end

  assign last_o = load_i ? (vl_i == beat_cnt_t'(1)) : (remain_q == beat_cnt_t'(1));

  a_vl_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    load_i |-> vl_i != '0);

endmodule

`default_nettype wire

//--- src/simd_alu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module simd_alu_ctrl import simd_alu_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      in_valid_i,
  input  logic      out_ready_i,
  input  logic      last_i,
  input  alu_op_e   op_i,
  input  alu_resp_t resp_i,
  output logic      in_ready_o,
  output logic      out_valid_o,
  output logic      load_o,
  output logic      use_acc_o,
  output logic      cnt_load_o,
  output logic      cnt_step_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        accept;
  logic        is_red;

  assign is_red      = op_i inside {VREDSUM, VREDMAXU, VREDMAX};
  assign out_valid_o = state_q == ST_HOLD;
  // A held result frees the register once it drains
  assign in_ready_o  = (state_q != ST_HOLD) || out_ready_i;
  assign accept      = in_valid_i && in_ready_o;

  assign load_o     = accept;
  assign use_acc_o  = state_q == ST_ACCUM;
  assign cnt_load_o = accept && is_red && (state_q != ST_ACCUM);
  assign cnt_step_o = accept && (state_q == ST_ACCUM);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_ACCUM: begin
        if (accept && last_i) state_d = ST_HOLD;
      end
      default: begin
        if (accept) begin
          state_d = (is_red && !last_i) ? ST_ACCUM : ST_HOLD;
        end else if (state_q == ST_HOLD && out_ready_i) begin
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(resp_i));

endmodule

`default_nettype wire

//--- src/simd_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module simd_alu_top import simd_alu_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  alu_req_t   req_i,
  input  simd_word_t operand_a_i,
  input  simd_word_t operand_b_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output alu_resp_t  resp_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);

  logic       load;
  logic       use_acc;
  logic       cnt_load;
  logic       cnt_step;
  logic       last;
  simd_word_t opa;
  alu_resp_t  alu_resp;

  simd_alu_ctrl i_simd_alu_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .out_ready_i (out_ready_i),
    .last_i      (last),
    .op_i        (req_i.op),
    .resp_i      (resp_o),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .load_o      (load),
    .use_acc_o   (use_acc),
    .cnt_load_o  (cnt_load),
    .cnt_step_o  (cnt_step)
  );

  simd_beat_counter i_simd_beat_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (cnt_load),
    .step_i  (cnt_step),
    .vl_i    (req_i.vl),
    .last_o  (last)
  );

  simd_accumulator i_simd_accumulator (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_i      (load),
    .use_acc_i   (use_acc),
    .operand_a_i (operand_a_i),
    .alu_resp_i  (alu_resp),
    .opa_o       (opa),
    .resp_o      (resp_o)
  );

  simd_lane_alu i_simd_lane_alu (
    .op_i   (req_i.op),
    .vew_i  (req_i.vew),
    .opa_i  (opa),
    .opb_i  (operand_b_i),
    .resp_o (alu_resp)
  );

endmodule

`default_nettype wire

//--- verification/tb_simd_alu_tasks.svh
`ifndef TB_SIMD_ALU_TASKS_SVH
`define TB_SIMD_ALU_TASKS_SVH

// Galois LFSR, one step per bit
function logic rand_bit();
  logic lsb;
  lsb    = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (lsb) lfsr_q = lfsr_q ^ 32'hb4bcd35c;
  return lsb;
endfunction

function int rand_bits(int n);
  int v;
  v = 0;
  for (int i = 0; i < n; i++) v = (v << 1) | int'(rand_bit());
  return v;
endfunction

function simd_word_t rand_word();
  simd_word_t w;
  for (int i = 0; i < 64; i++) w[i] = rand_bit();
  return w;
endfunction

// One bit below each element's MSB, in even or odd elements
function automatic simd_word_t top_bits(elem_width_e vew, logic even, int off);
  int ew;
  simd_word_t w;
  ew = 8 << int'(vew);
  w  = '0;
  for (int e = 0; e < 64 / ew; e++) begin
    if ((e % 2 == 0) == even) w[e * ew + ew - 1 - off] = 1'b1;
  end
  return w;
endfunction

// Behavioral model, one element at a time
function automatic alu_resp_t model_resp(alu_op_e op, elem_width_e vew,
                                         simd_word_t a, simd_word_t b);
  int ew;
  logic [65:0] mask;
  logic [65:0] smax;
  logic [65:0] ea;
  logic [65:0] eb;
  logic [65:0] r;
  logic signed [65:0] sa;
  logic signed [65:0] sb;
  logic signed [65:0] sfull;
  logic s;
  alu_resp_t resp;
  ew   = 8 << int'(vew);
  mask = (66'd1 << ew) - 66'd1;
  smax = mask >> 1;
  resp = '0;
  for (int e = 0; e < 64 / ew; e++) begin
    ea = ({2'b00, a} >> (e * ew)) & mask;
    eb = ({2'b00, b} >> (e * ew)) & mask;
    sa = ea[ew-1] ? $signed(ea | ~mask) : $signed(ea);
    sb = eb[ew-1] ? $signed(eb | ~mask) : $signed(eb);
    s  = 1'b0;
    case (op)
      VAND:             r = ea & eb;
      VOR:              r = ea | eb;
      VXOR:             r = ea ^ eb;
      VADD, VREDSUM:    r = eb + ea;
      VSUB:             r = eb - ea;
      VSADDU: begin
        r = eb + ea;
        s = r > mask;
        if (s) r = mask;
      end
      VSADD: begin
        sfull = sb + sa;
        if (sfull > $signed(smax)) begin
          s = 1'b1;
          r = smax;
        end else if (sfull < -$signed(smax) - 1) begin
          s = 1'b1;
          r = ~smax;
        end else begin
          r = $unsigned(sfull);
        end
      end
      VSSUBU: begin
        s = eb < ea;
        r = s ? 66'd0 : eb - ea;
      end
      VMINU:             r = (eb < ea) ? eb : ea;
      VMIN:              r = (sb < sa) ? eb : ea;
      VMAXU, VREDMAXU:   r = (eb > ea) ? eb : ea;
      VMAX, VREDMAX:     r = (sb > sa) ? eb : ea;
      VMSEQ:             r = {65'd0, eb == ea};
      VMSLTU:            r = {65'd0, eb < ea};
      VMSLT:             r = {65'd0, sb < sa};
      default:           r = '0;
    endcase
    resp.data = resp.data | 64'((r & mask) << (e * ew));
    if (s) begin
      for (int k = 0; k < ew / 8; k++) resp.sat[e * ew / 8 + k] = 1'b1;
    end
  end
  return resp;
endfunction

task automatic compare_word(string name, simd_word_t exp, simd_word_t act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("Fail %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic compare_strb(string name, byte_strb_t exp, byte_strb_t act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("Fail %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic compare_flag(string name, logic exp, logic act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("Fail %s: expected %b, actual %b", name, exp, act);
  end
endtask

// Called by the monitor when a result transfers at the next rising edge
task automatic check_output();
  alu_resp_t e;
  int c;
  if (exp_q.size() == 0) begin
    errors++;
    $display("Error: %s produced a response that no request asked for", cur_test);
  end else begin
    e = exp_q.pop_front();
    c = cyc_q.pop_front();
    compare_word({cur_test, " data"}, e.data, resp_o.data);
    compare_strb({cur_test, " sat"}, e.sat, resp_o.sat);
    if (check_latency) compare_flag({cur_test, " latency"}, 1'b1, cyc == c);
  end
endtask

task automatic send_beat(alu_req_t req, simd_word_t a, simd_word_t b,
                         logic has_out, alu_resp_t exp);
  @(negedge clk_i);
  req_i       = req;
  operand_a_i = a;
  operand_b_i = b;
  in_valid_i  = 1'b1;
  // in_ready_o is settled a quarter period after the falling edge
  #(clk_period / 4);
  while (!in_ready_o) begin
    @(negedge clk_i);
    #(clk_period / 4);
  end
  @(posedge clk_i);
  if (has_out) begin
    exp_q.push_back(exp);
    cyc_q.push_back(cyc);
  end
endtask

task automatic drain();
  int n;
  @(negedge clk_i);
  in_valid_i = 1'b0;
  n = 0;
  while (exp_q.size() != 0 && n < 100) begin
    @(posedge clk_i);
    n++;
  end
  if (exp_q.size() != 0) begin
    errors++;
    $display("Error: no response for %0d requests in %s", exp_q.size(), cur_test);
  end
  repeat (2) @(posedge clk_i);
  exp_q.delete();
  cyc_q.delete();
endtask

////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic test_reset_state();
  cur_test = "reset";
  compare_flag("reset out_valid", 1'b0, out_valid_o);
  compare_flag("reset in_ready", 1'b1, in_ready_o);
endtask

task automatic run_ops(alu_op_e op, int pairs, int shape);
  simd_word_t a;
  simd_word_t b;
  simd_word_t clr;
  elem_width_e vew;
  for (int w = 0; w < 4; w++) begin
    vew = elem_width_e'(w);
    clr = top_bits(vew, 1, 0) | top_bits(vew, 1, 1) | top_bits(vew, 0, 0) | top_bits(vew, 0, 1);
    for (int i = 0; i < pairs; i++) begin
      a = rand_word();
      b = rand_word();
      if (shape == 1) begin
        // Even elements overflow, odd ones do not
        if (op == VSADD && i % 2 == 1) begin
          // Both negative, clips to the signed minimum
          a = (a & ~clr) | top_bits(vew, 1, 0);
        end else begin
          a = (a & ~clr) | top_bits(vew, 1, 1) | (op == VSADD ? '0 : top_bits(vew, 1, 0));
        end
        b = (op == VSSUBU) ? (b & ~clr) | top_bits(vew, 0, 0) | top_bits(vew, 0, 1)
                           : (b & ~clr) | (a & clr);
      end else if (shape == 2) begin
        b = (b & ~top_bits(vew, 1, 0) & ~top_bits(vew, 0, 0))
          | (~a & (top_bits(vew, 1, 0) | top_bits(vew, 0, 0)));
        if (op == VMSEQ && i % 2 == 0) b = a;
      end
      send_beat('{op: op, vew: vew, vl: beat_cnt_t'(1)}, a, b, 1'b1,
                model_resp(op, vew, a, b));
    end
  end
  drain();
endtask

task automatic test_basic_ops();
  alu_op_e ops[5] = '{VAND, VOR, VXOR, VADD, VSUB};
  foreach (ops[i]) begin
    cur_test = {"basic ", ops[i].name()};
    run_ops(ops[i], 20, 0);
  end
endtask

task automatic test_saturating();
  alu_op_e ops[3] = '{VSADDU, VSADD, VSSUBU};
  foreach (ops[i]) begin
    cur_test = {"saturating ", ops[i].name()};
    run_ops(ops[i], 8, 1);
  end
endtask

task automatic test_minmax_cmp();
  alu_op_e ops[7] = '{VMINU, VMIN, VMAXU, VMAX, VMSEQ, VMSLTU, VMSLT};
  foreach (ops[i]) begin
    cur_test = {"minmax/compare ", ops[i].name()};
    run_ops(ops[i], 8, 2);
  end
endtask

// Reduction of vl beats, the first carries the seed in operand A
task automatic send_reduction(alu_op_e op, elem_width_e vew, int vl);
  simd_word_t acc;
  simd_word_t b;
  alu_resp_t exp;
  acc = rand_word();
  for (int k = 0; k < vl; k++) begin
    b   = rand_word();
    exp = model_resp(op, vew, acc, b);
    send_beat('{op: op, vew: vew, vl: beat_cnt_t'(vl)}, (k == 0) ? acc : rand_word(), b,
              k == vl - 1, exp);
    acc = exp.data;
  end
endtask

task automatic test_reductions();
  alu_op_e ops[3] = '{VREDSUM, VREDMAXU, VREDMAX};
  int vls[3] = '{1, 3, 15};
  foreach (ops[i]) begin
    cur_test = {"reduction ", ops[i].name()};
    for (int w = 0; w < 4; w++) begin
      foreach (vls[j]) send_reduction(ops[i], elem_width_e'(w), vls[j]);
    end
    drain();
  end
endtask

task automatic test_backpressure();
  simd_word_t a;
  simd_word_t b;
  alu_op_e op;
  elem_width_e vew;
  cur_test      = "backpressure";
  bp_enable     = 1'b1;
  check_latency = 1'b0;
  for (int r = 0; r < 4; r++) begin
    for (int i = 0; i < 10; i++) begin
      op  = alu_op_e'(rand_bits(5) % 15);
      vew = elem_width_e'(rand_bits(2));
      a   = rand_word();
      b   = rand_word();
      send_beat('{op: op, vew: vew, vl: beat_cnt_t'(1)}, a, b, 1'b1, model_resp(op, vew, a, b));
    end
    send_reduction(alu_op_e'(int'(VREDSUM) + r % 3), elem_width_e'(r), 6);
  end
  drain();
  bp_enable     = 1'b0;
  check_latency = 1'b1;
endtask

`endif

//--- verification/tb_simd_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_simd_alu import simd_alu_pkg::*; ();

  localparam int total_beats = 1012;
  localparam int clk_period  = 100;

  logic       clk_i;
  logic       reset_i;
  alu_req_t   req_i;
  simd_word_t operand_a_i;
  simd_word_t operand_b_i;
  logic       in_valid_i;
  logic       in_ready_o;
  alu_resp_t  resp_o;
  logic       out_valid_o;
  logic       out_ready_i;

  // Scoreboard and run state
  alu_resp_t  exp_q[$];
  int         cyc_q[$];
  int         cyc;
  int         checks;
  int         errors;
  logic       bp_enable;
  logic       check_latency;
  logic       stalled;
  alu_resp_t  held;
  logic [31:0] lfsr_q;
  string      cur_test;

  `include "tb_simd_alu_tasks.svh"

  simd_alu_top i_simd_alu_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .resp_o      (resp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  initial begin
    #(total_beats * 4 * clk_period + 5 * clk_period);
    $display("Error: watchdog timeout, the DUT stopped making progress");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Output monitor, sampled at the falling edge where outputs are stable

  initial begin
    forever begin
      @(negedge clk_i);
      if (stalled) begin
        compare_word("stall hold data", held.data, resp_o.data);
        compare_strb("stall hold sat", held.sat, resp_o.sat);
        compare_flag("stall hold valid", 1'b1, out_valid_o);
      end
      // Ready for the coming rising edge
      out_ready_i = bp_enable ? (rand_bits(2) != 0) : 1'b1;
      stalled     = out_valid_o && !out_ready_i;
      held        = resp_o;
      if (out_valid_o && out_ready_i) begin
        check_output();
      end
      cyc = cyc + 1;
    end
  end

  initial begin
    lfsr_q        = 32'hb5c1c0e0;
    req_i         = '{op: VAND, vew: EW8, vl: beat_cnt_t'(1)};
    operand_a_i   = '0;
    operand_b_i   = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    reset_i       = 1'b1;
    cyc           = 0;
    checks        = 0;
    errors        = 0;
    bp_enable     = 1'b0;
    check_latency = 1'b1;
    stalled       = 1'b0;
    held          = '0;
    cur_test      = "reset";
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_reset_state();
    test_basic_ops();
    test_saturating();
    test_minmax_cmp();
    test_reductions();
    test_backpressure();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
+incdir+verification
src/simd_alu_pkg.sv
src/simd_compare_unit.sv
src/simd_lane_alu.sv
src/simd_accumulator.sv
src/simd_beat_counter.sv
src/simd_alu_ctrl.sv
src/simd_alu_top.sv
verification/tb_simd_alu.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
rm -f build.log sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_simd_alu \
  -o sim_tb > build.log 2>&1 && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Testbench failed" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
exit 0
